// File: compile.f
src/cluster_cfg_pkg.sv
src/req_chan_pkg.sv
src/req_cut.sv
src/req_arbiter.sv
src/cdc_src_half.sv
src/cluster_req_wrap.sv
dv/cdc_dst_model.sv
dv/tb_cluster_req_wrap.sv

// File: Bender.yml
package:
  name: cluster_req_wrap

sources:
  # Packages first, then leaf modules, then the top level
  - src/cluster_cfg_pkg.sv
  - src/req_chan_pkg.sv
  - src/req_cut.sv
  - src/req_arbiter.sv
  - src/cdc_src_half.sv
  - src/cluster_req_wrap.sv

  - target: test
    files:
      - dv/cdc_dst_model.sv
      - dv/tb_cluster_req_wrap.sv

// File: dv/tb_cluster_req_wrap.sv
`timescale 1ns/1ps

module tb_cluster_req_wrap
  import cluster_cfg_pkg::*;
  import req_chan_pkg::*;
;

  typedef enum int {
    ModeRandom,
    ModeHold,
    ModeIdle
  } stim_mode_e;

  // Four phases of roughly 600 cycles each plus margin
  localparam int TimeoutCycles = 4 * 600 + 600;

  // Upper bound on one drain, well above the six entries in flight
  localparam int DrainCycles = 200;

  logic                      clk;
  logic                      rst_n;
  core_req_t                 core0_req;
  core_req_t                 core1_req;
  logic                      core0_valid;
  logic                      core1_valid;
  logic                      core0_ready;
  logic                      core1_ready;
  logic [PtrWidth-1:0]       wptr;
  logic [SlotArrayWidth-1:0] data;
  logic [PtrWidth-1:0]       rptr;
  logic                      pause;
  logic                      pop_valid;
  out_req_t                  pop_req;

  logic [31:0]         lfsr_state;
  logic                acc0;
  logic                acc1;
  out_req_t            exp_q0[$];
  out_req_t            exp_q1[$];
  logic [PtrWidth-1:0] prev_wptr;
  logic                alt_check_on;
  int                  alt_pops;
  logic                last_core;
  logic                pause_check_on;
  int                  paused_moves;
  int                  cycle_cnt;
  int                  waited;

  cluster_req_wrap i_dut (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .core0_req_i   ( core0_req   ),
    .core0_valid_i ( core0_valid ),
    .core0_ready_o ( core0_ready ),
    .core1_req_i   ( core1_req   ),
    .core1_valid_i ( core1_valid ),
    .core1_ready_o ( core1_ready ),
    .wptr_o        ( wptr        ),
    .data_o        ( data        ),
    .rptr_i        ( rptr        )
  );

  cdc_dst_model i_dst (
    .clk_i     ( clk       ),
    .rst_n_i   ( rst_n     ),
    .wptr_i    ( wptr      ),
    .data_i    ( data      ),
    .rptr_o    ( rptr      ),
    .pause_i   ( pause     ),
    .pop_o     ( pop_valid ),
    .pop_req_o ( pop_req   )
  );

  always #20 clk = ~clk;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp_val);
    $display("error: %s got 0x%0h expected 0x%0h", sig, got, exp_val);
    $display("Errors found");
    $fatal(1);
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits       = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic core_req_t random_req();
    core_req_t   r;
    logic [31:0] bits;
    bits   = take_bits(CoreIdWidth);
    r.id   = bits[CoreIdWidth-1:0];
    r.addr = take_bits(AddrWidth);
    bits   = take_bits(LenWidth);
    r.len  = bits[LenWidth-1:0];
    bits   = take_bits(1);
    r.we   = bits[0];
    return r;
  endfunction

  // Core index goes above the local ID
  function automatic out_req_t expect_word(input logic core, input core_req_t r);
    out_req_t w;
    w.id   = {core, r.id};
    w.addr = r.addr;
    w.len  = r.len;
    w.we   = r.we;
    return w;
  endfunction

  function automatic logic [PtrWidth-1:0] gray_to_bin(input logic [PtrWidth-1:0] g);
    logic [PtrWidth-1:0] b;
    b[PtrWidth-1] = g[PtrWidth-1];
    for (int i = PtrWidth - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  function automatic logic pick_valid(input stim_mode_e mode);
    logic [31:0] bits;
    bits = take_bits(1);
    if (mode == ModeHold) begin
      return 1'b1;
    end
    if (mode == ModeIdle) begin
      return 1'b0;
    end
    return bits[0];
  endfunction

  // Payload only moves once the previous request was taken
  task automatic drive_cycle(input stim_mode_e mode);
    @(posedge clk);
    #2;
    if (!core0_valid || acc0) begin
      core0_valid = pick_valid(mode);
      core0_req   = random_req();
    end
    if (!core1_valid || acc1) begin
      core1_valid = pick_valid(mode);
      core1_req   = random_req();
    end
    if (mode == ModeRandom) begin
      pause = (take_bits(2) == 32'd0);
    end
  endtask

  task automatic drain();
    int idle_cycles;
    idle_cycles = 0;
    do begin
      drive_cycle(ModeIdle);
      idle_cycles++;
    end while ((core0_valid || core1_valid || exp_q0.size() != 0 || exp_q1.size() != 0)
               && idle_cycles < DrainCycles);
    assert (!core0_valid && !core1_valid && exp_q0.size() == 0 && exp_q1.size() == 0)
      else report_failure("requests still pending after the drain window");
  endtask

  // --------------------------------------------------------------------------
  // Checks on the export side
  // --------------------------------------------------------------------------

  task automatic check_pop();
    out_req_t exp_word;
    logic     core;
    core = pop_req.id[OutIdWidth-1];
    if (core) begin
      assert (exp_q1.size() > 0) else report_failure("pop with no pending request from core 1");
      exp_word = exp_q1.pop_front();
    end else begin
      assert (exp_q0.size() > 0) else report_failure("pop with no pending request from core 0");
      exp_word = exp_q0.pop_front();
    end
    assert (pop_req.id == exp_word.id)
      else report_mismatch("data_o.id", pop_req.id, exp_word.id);
    assert (pop_req.addr == exp_word.addr)
      else report_mismatch("data_o.addr", pop_req.addr, exp_word.addr);
    assert (pop_req.len == exp_word.len)
      else report_mismatch("data_o.len", pop_req.len, exp_word.len);
    assert (pop_req.we == exp_word.we)
      else report_mismatch("data_o.we", pop_req.we, exp_word.we);
    if (alt_check_on) begin
      if (alt_pops > 0) begin
        assert (core != last_core)
          else report_failure($sformatf("two pops in a row from core %0d under full load", core));
      end
      alt_pops++;
    end
    last_core = core;
  endtask

  task automatic check_pointers();
    logic [PtrWidth-1:0] diff;
    logic [PtrWidth-1:0] fill;
    diff = wptr ^ prev_wptr;
    if (diff != '0) begin
      assert ((diff & (diff - PtrWidth'(1))) == '0)
        else report_failure($sformatf("wptr_o moved from 0x%0h to 0x%0h", prev_wptr, wptr));
      if (pause_check_on) begin
        paused_moves++;
        assert (paused_moves <= 2)
          else report_failure("wptr_o advanced over two times while paused");
      end
    end
    fill = gray_to_bin(wptr) - gray_to_bin(rptr);
    assert (fill <= FifoDepth) else report_failure("wptr_o ran more than two entries ahead");
    prev_wptr = wptr;
  endtask

  // Sampled half a cycle away from the active edge
  always @(negedge clk) begin
    if (rst_n) begin
      acc0 = core0_valid && core0_ready;
      acc1 = core1_valid && core1_ready;
      if (acc0) begin
        exp_q0.push_back(expect_word(1'b0, core0_req));
      end
      if (acc1) begin
        exp_q1.push_back(expect_word(1'b1, core1_req));
      end
      if (pop_valid) begin
        check_pop();
      end
      check_pointers();
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      report_failure("simulation did not finish within the cycle limit");
    end
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    core0_req      = '0;
    core1_req      = '0;
    core0_valid    = 1'b0;
    core1_valid    = 1'b0;
    pause          = 1'b0;
    lfsr_state     = 32'h40961df4;
    acc0           = 1'b0;
    acc1           = 1'b0;
    prev_wptr      = '0;
    alt_check_on   = 1'b0;
    alt_pops       = 0;
    last_core      = 1'b0;
    pause_check_on = 1'b0;
    paused_moves   = 0;
    cycle_cnt      = 0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    assert (wptr == '0) else report_mismatch("wptr_o", wptr, 0);
    assert (core0_ready && core1_ready) else report_failure("core ready low after reset");

    // Random traffic with a randomly stalling reader
    repeat (600) drive_cycle(ModeRandom);
    pause = 1'b0;
    drain();

    // Both cores saturated so pops alternate once the cuts are full
    repeat (20) drive_cycle(ModeHold);
    alt_pops     = 0;
    alt_check_on = 1'b1;
    repeat (400) drive_cycle(ModeHold);
    alt_check_on = 1'b0;
    assert (alt_pops >= 20) else report_failure("too few pops while both cores held valid");
    drain();

    // Frozen reader
    pause          = 1'b1;
    paused_moves   = 0;
    pause_check_on = 1'b1;
    waited         = 0;
    do begin
      drive_cycle(ModeHold);
      waited++;
    end while ((core0_ready || core1_ready) && waited < 40);
    assert (!core0_ready && !core1_ready)
      else report_failure("core ready stayed high while paused");
    repeat (10) drive_cycle(ModeHold);
    pause_check_on = 1'b0;
    pause          = 1'b0;
    drain();

    repeat (10) drive_cycle(ModeIdle);
    $display("No errors");
    $finish;
  end

endmodule

// File: dv/cdc_dst_model.sv
`timescale 1ns/1ps

module cdc_dst_model
  import cluster_cfg_pkg::*;
  import req_chan_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // From the FIFO source half
  input  logic [PtrWidth-1:0]       wptr_i,
  input  logic [SlotArrayWidth-1:0] data_i,
  output logic [PtrWidth-1:0]       rptr_o,
  // Holds the reader idle while high
  input  logic                      pause_i,
  // Word taken at the next rising edge
  output logic                      pop_o,
  output out_req_t                  pop_req_o
);

  out_req_t [FifoDepth-1:0] slots;
  logic [1:0][PtrWidth-1:0] wptr_sync_q;
  logic [PtrWidth-1:0]      rd_bin_q;
  logic [PtrWidth-1:0]      rd_bin_next;
  logic [PtrWidth-1:0]      rptr_q;

  assign slots = data_i;

  // Data is present while the synchronized write pointer differs
  assign pop_o       = (wptr_sync_q[1] != rptr_q) && !pause_i;
  assign pop_req_o   = slots[rd_bin_q[LogDepth-1:0]];
  assign rd_bin_next = rd_bin_q + PtrWidth'(1);
  assign rptr_o      = rptr_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wptr_sync_q <= '0;
      rd_bin_q    <= '0;
      rptr_q      <= '0;
    end else begin
      wptr_sync_q[0] <= wptr_i;
      wptr_sync_q[1] <= wptr_sync_q[0];
      if (pop_o) begin
        rd_bin_q <= rd_bin_next;
        // One gray step per pop
        rptr_q   <= rd_bin_next ^ (rd_bin_next >> 1);
      end
    end
  end

endmodule

// File: src/cluster_req_wrap.sv
`timescale 1ns/1ps

module cluster_req_wrap
  import cluster_cfg_pkg::*;
  import req_chan_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Core 0 request port
  input  core_req_t                 core0_req_i,
  input  logic                      core0_valid_i,
  output logic                      core0_ready_o,
  // Core 1 request port
  input  core_req_t                 core1_req_i,
  input  logic                      core1_valid_i,
  output logic                      core1_ready_o,
  // Async FIFO source side
  output logic [PtrWidth-1:0]       wptr_o,
  output logic [SlotArrayWidth-1:0] data_o,
  input  logic [PtrWidth-1:0]       rptr_i
);

  out_req_t cut0_req;
  logic     cut0_valid;
  logic     cut0_ready;
  out_req_t cut1_req;
  logic     cut1_valid;
  logic     cut1_ready;
  out_req_t arb_req;
  logic     arb_valid;
  logic     arb_ready;

  // --------------------------------------------------------------------------
  // Per-core register cuts
  // --------------------------------------------------------------------------

  req_cut #(
    .SrcIdx ( 0 )
  ) i_cut0 (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .in_req_i    ( core0_req_i   ),
    .in_valid_i  ( core0_valid_i ),
    .in_ready_o  ( core0_ready_o ),
    .out_req_o   ( cut0_req      ),
    .out_valid_o ( cut0_valid    ),
    .out_ready_i ( cut0_ready    )
  );

  req_cut #(
    .SrcIdx ( 1 )
  ) i_cut1 (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .in_req_i    ( core1_req_i   ),
    .in_valid_i  ( core1_valid_i ),
    .in_ready_o  ( core1_ready_o ),
    .out_req_o   ( cut1_req      ),
    .out_valid_o ( cut1_valid    ),
    .out_ready_i ( cut1_ready    )
  );

  // --------------------------------------------------------------------------
  // Merge and export
  // --------------------------------------------------------------------------

  req_arbiter i_arb (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .req_a_i     ( cut0_req   ),
    .valid_a_i   ( cut0_valid ),
    .ready_a_o   ( cut0_ready ),
    .req_b_i     ( cut1_req   ),
    .valid_b_i   ( cut1_valid ),
    .ready_b_o   ( cut1_ready ),
    .out_req_o   ( arb_req    ),
    .out_valid_o ( arb_valid  ),
    .out_ready_i ( arb_ready  )
  );

  cdc_src_half i_cdc_src (
    .clk_i      ( clk_i     ),
    .rst_n_i    ( rst_n_i   ),
    .in_req_i   ( arb_req   ),
    .in_valid_i ( arb_valid ),
    .in_ready_o ( arb_ready ),
    .wptr_o     ( wptr_o    ),
    .data_o     ( data_o    ),
    .rptr_i     ( rptr_i    )
  );

endmodule

// File: src/cdc_src_half.sv
`timescale 1ns/1ps

module cdc_src_half
  import cluster_cfg_pkg::*;
  import req_chan_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Request stream from the arbiter
  input  out_req_t                  in_req_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  // Toward the far clock domain
  output logic [PtrWidth-1:0]       wptr_o,
  output logic [SlotArrayWidth-1:0] data_o,
  input  logic [PtrWidth-1:0]       rptr_i
);

  out_req_t [FifoDepth-1:0]      slot_q;
  logic [PtrWidth-1:0]           wr_bin_q;
  logic [PtrWidth-1:0]           wr_bin_next;
  logic [PtrWidth-1:0]           wptr_q;
  // Stage 0 is the metastability flop, stage 1 is safe to use
  logic [1:0][PtrWidth-1:0]      rptr_sync_q;
  logic [PtrWidth-1:0]           full_ptr;
  logic                          full;
  logic                          push;

  // --------------------------------------------------------------------------
  // Read pointer synchronizer
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rptr_sync_q <= '0;
    end else begin
      rptr_sync_q[0] <= rptr_i;
      rptr_sync_q[1] <= rptr_sync_q[0];
    end
  end

  // --------------------------------------------------------------------------
  // Full detection
  // --------------------------------------------------------------------------

  // Gray full: top two bits inverted, the rest equal
  assign full_ptr = wptr_q ^ (PtrWidth'(3) << (PtrWidth - 2));
  assign full     = (rptr_sync_q[1] == full_ptr);

  assign in_ready_o = ~full;
  assign push       = in_valid_i & in_ready_o;

  // --------------------------------------------------------------------------
  // Write pointer
  // --------------------------------------------------------------------------

  assign wr_bin_next = wr_bin_q + PtrWidth'(1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_bin_q <= '0;
      wptr_q   <= '0;
    end else if (push) begin
      wr_bin_q <= wr_bin_next;
      // One gray step per push
      wptr_q   <= wr_bin_next ^ (wr_bin_next >> 1);
    end
  end

  // Slot storage, indexed by the low counter bits
  always_ff @(posedge clk_i) begin
    if (push) begin
      slot_q[wr_bin_q[LogDepth-1:0]] <= in_req_i;
    end
  end

  assign wptr_o = wptr_q;
  assign data_o = slot_q;

endmodule

// File: src/req_arbiter.sv
`timescale 1ns/1ps

module req_arbiter
  import req_chan_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Input from cut 0
  input  out_req_t req_a_i,
  input  logic     valid_a_i,
  output logic     ready_a_o,
  // Input from cut 1
  input  out_req_t req_b_i,
  input  logic     valid_b_i,
  output logic     ready_b_o,
  // Merged stream
  output out_req_t out_req_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  // Priority flag, 0 favours core 0
  logic prio_q;
  // Grant held while a request waits for ready
  logic lock_q;
  logic lock_sel_q;
  logic sel;

  // --------------------------------------------------------------------------
  // Grant selection
  // --------------------------------------------------------------------------

  always_comb begin
    if (lock_q) begin
      sel = lock_sel_q;
    end else if (valid_a_i && valid_b_i) begin
      sel = prio_q;
    end else if (valid_b_i) begin
      sel = 1'b1;
    end else begin
      sel = 1'b0;
    end
  end

  assign out_valid_o = sel ? valid_b_i : valid_a_i;
  assign out_req_o   = sel ? req_b_i : req_a_i;

  // Only the chosen input sees ready
  assign ready_a_o = out_ready_i & ~sel;
  assign ready_b_o = out_ready_i & sel;

  // --------------------------------------------------------------------------
  // Priority and lock
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q     <= 1'b0;
      lock_q     <= 1'b0;
      lock_sel_q <= 1'b0;
    end else if (out_valid_o) begin
      if (out_ready_i) begin
        // Transfer done, hand priority to the other core
        lock_q <= 1'b0;
        prio_q <= ~sel;
      end else begin
        lock_q     <= 1'b1;
        lock_sel_q <= sel;
      end
    end
  end

endmodule

// File: src/req_cut.sv
`timescale 1ns/1ps

module req_cut
  import cluster_cfg_pkg::*;
  import req_chan_pkg::*;
#(
  parameter int unsigned SrcIdx = 0
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Core side
  input  core_req_t in_req_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  // Arbiter side
  output out_req_t  out_req_o,
  output logic      out_valid_o,
  input  logic      out_ready_i
);

  out_req_t [1:0] entry_q;
  logic           wr_idx_q;
  logic           rd_idx_q;
  logic [1:0]     cnt_q;
  out_req_t       in_word;
  logic           push;
  logic           pop;

  // --------------------------------------------------------------------------
  // Widen the ID on entry
  // --------------------------------------------------------------------------

  always_comb begin
    in_word.id   = {SrcIdWidth'(SrcIdx), in_req_i.id};
    in_word.addr = in_req_i.addr;
    in_word.len  = in_req_i.len;
    in_word.we   = in_req_i.we;
  end

  // Ready comes straight from the fill count
  assign in_ready_o  = (cnt_q != 2'd2);
  assign out_valid_o = (cnt_q != 2'd0);
  assign out_req_o   = entry_q[rd_idx_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // --------------------------------------------------------------------------
  // Fill state
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_idx_q <= 1'b0;
      rd_idx_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) begin
        wr_idx_q <= ~wr_idx_q;
      end
      if (pop) begin
        rd_idx_q <= ~rd_idx_q;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 2'd1;
        2'b01:   cnt_q <= cnt_q - 2'd1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_q[wr_idx_q] <= in_word;
    end
  end

endmodule

// File: src/req_chan_pkg.sv
package req_chan_pkg;

  import cluster_cfg_pkg::*;

  // --------------------------------------------------------------------------
  // Request words
  // --------------------------------------------------------------------------

  // As issued by a core
  typedef struct packed {
    logic [CoreIdWidth-1:0] id;
    logic [AddrWidth-1:0]   addr;
    logic [LenWidth-1:0]    len;
    logic                   we;
  } core_req_t;

  // Export format, ID carries the core index in its top bit
  typedef struct packed {
    logic [OutIdWidth-1:0] id;
    logic [AddrWidth-1:0]  addr;
    logic [LenWidth-1:0]   len;
    logic                  we;
  } out_req_t;

  // --------------------------------------------------------------------------
  // Widths at the FIFO boundary
  // --------------------------------------------------------------------------

  localparam int unsigned OutReqWidth = $bits(out_req_t);

  // Flat slot array, slot k at bit offset k * OutReqWidth
  localparam int unsigned SlotArrayWidth = FifoDepth * OutReqWidth;

endpackage

// File: src/cluster_cfg_pkg.sv
package cluster_cfg_pkg;

  // --------------------------------------------------------------------------
  // Cluster sizing
  // --------------------------------------------------------------------------

  localparam int unsigned NumCores = 2;

  // Local ID width as seen at each core port
  localparam int unsigned CoreIdWidth = 2;

  // Prefix that names the source core
  localparam int unsigned SrcIdWidth = $clog2(NumCores);

  localparam int unsigned OutIdWidth = CoreIdWidth + SrcIdWidth;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned LenWidth = 8;

  // --------------------------------------------------------------------------
  // Export FIFO geometry
  // --------------------------------------------------------------------------

  localparam int unsigned LogDepth = 1;
  localparam int unsigned FifoDepth = 2 ** LogDepth;

  // One extra bit to tell full from empty
  localparam int unsigned PtrWidth = LogDepth + 1;

endpackage
